// ==== src.f ====
verilog/csr_pkg.sv
verilog/csr_access_decode.sv
verilog/machine_trap_regs.sv
verilog/priority_encoder.sv
verilog/trap_request.sv
verilog/csr_read_mux.sv
verilog/csr_top.sv
test/tb_csr_properties.sv
test/tb_csr.sv

// ==== test/tb_csr.sv ====
`timescale 1ns/1ps

module tb_csr;

	import csr_pkg::*;

	localparam int CLK_PERIOD = 100;
	// Cycle budgets of reset and tests 1 to 6
	localparam int BUDGET = 5 + 40 + 15 + 30 + 70 + 30 + 30;

	logic            clk;
	logic            rst_n;
	csr_addr_t       addr;
	logic [31:0]     wdata;
	csr_wtype_t      wtype;
	logic            wen;
	logic            ren;
	logic [31:0]     rdata;
	logic            illegal;
	except_t         except;
	logic [31:0]     mepc_in;
	logic [15:0]     irq;
	logic            irq_timer;
	logic            irq_software;
	logic [31:0]     trap_addr;
	logic            trap_is_irq;
	logic            trap_enter_vld;
	logic            trap_enter_rdy;

	integer          seed = 56458;
	int              errors = 0;       // Value check failures
	int              tests = 0;
	int              failed_tests = 0;
	int              test_start = 0;   // Error count when a test began
	int              k;                // Winning external line
	logic [31:0]     rd_data;          // Last read sampled mid-cycle
	logic            rd_ill;
	logic [31:0]     d1;               // Random data words
	logic [31:0]     d2;
	logic [31:0]     d3;
	logic [31:0]     wmask;
	logic [31:0]     exp_v;
	logic [31:0]     exp_epc;
	csr_addr_t       a_sel;

	csr_top #(.NUM_IRQ(16)) u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(BUDGET * CLK_PERIOD);
		$display("Watchdog expired at %0t ns, tests did not finish in time", $time);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------

	task automatic access(input logic do_wr, input csr_wtype_t wt, input csr_addr_t a,
		input logic [31:0] d);
		@(posedge clk);
		#10;
		addr  = a;
		wtype = wt;
		wdata = d;
		wen   = do_wr;
		ren   = !do_wr;
		@(negedge clk); // Read port is combinational
		rd_data = rdata;
		rd_ill  = illegal;
		@(posedge clk); // Write lands here
		#10;
		wen = 1'b0;
		ren = 1'b0;
	endtask

	task automatic write_csr(input csr_wtype_t wt, input csr_addr_t a, input logic [31:0] d);
		access(1'b1, wt, a, d);
	endtask

	task automatic read_csr(input csr_addr_t a);
		access(1'b0, CSR_WTYPE_W, a, 32'h0);
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic wait_vld(input int max_cycles);
		int n;
		n = 0;
		@(negedge clk);
		while (!trap_enter_vld && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
		if (!trap_enter_vld) begin
			$display("Timeout at %0t ns, trap_enter_vld never rose", $time);
			errors++;
		end
	endtask

	// One cycle of rdy and the entry commits on that edge
	task automatic complete_handshake();
		@(posedge clk);
		#10;
		trap_enter_rdy = 1'b1;
		@(posedge clk);
		#10;
		trap_enter_rdy = 1'b0;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_start) begin
			$display("Test %0d %s: passed", tests, name);
		end else begin
			failed_tests++;
			$display("Test %0d %s: failed", tests, name);
		end
		test_start = errors;
	endtask

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------

	initial begin
		rst_n          = 1'b0;
		addr           = '0;
		wdata          = '0;
		wtype          = CSR_WTYPE_W;
		wen            = 1'b0;
		ren            = 1'b0;
		except         = EXCEPT_NONE;
		mepc_in        = '0;
		irq            = '0;
		irq_timer      = 1'b0;
		irq_software   = 1'b0;
		trap_enter_rdy = 1'b0;
		repeat (2) @(posedge clk);
		#10;
		rst_n = 1'b1;

		for (int r = 0; r < 2; r++) begin // mscratch then mie
			a_sel = (r == 0) ? MSCRATCH : MIE;
			wmask = (r == 0) ? 32'hffff_ffff : 32'h0000_0888;
			d1    = $random(seed);
			d2    = $random(seed);
			d3    = $random(seed);
			write_csr(CSR_WTYPE_W, a_sel, d1);
			read_csr(a_sel);
			exp_v = d1 & wmask;
			check_value("csr after write", rd_data, exp_v);
			write_csr(CSR_WTYPE_S, a_sel, d2);
			read_csr(a_sel);
			exp_v = (exp_v | d2) & wmask;
			check_value("csr after set", rd_data, exp_v);
			write_csr(CSR_WTYPE_C, a_sel, d3);
			read_csr(a_sel);
			exp_v = exp_v & ~d3;
			check_value("csr after clear", rd_data, exp_v);
		end
		end_test("write set clear");

		read_csr(12'h7c0); // Nothing lives here
		check_value("unmapped read illegal", rd_ill, 1'b1);
		write_csr(CSR_WTYPE_W, MEIP0, d1);
		check_value("meip0 write illegal", rd_ill, 1'b1);
		read_csr(MEPC);
		check_value("mepc read illegal", rd_ill, 1'b0);
		end_test("illegal access");

		write_csr(CSR_WTYPE_W, MTVEC, 32'h0000_1000); // Direct mode
		write_csr(CSR_WTYPE_W, MSTATUS, 32'h0000_0008); // mie=1, mpie=0
		exp_epc = $random(seed);
		@(posedge clk);
		#10;
		except         = EXCEPT_ECALL;
		mepc_in        = exp_epc | 32'h1;
		trap_enter_rdy = 1'b1;
		wait_vld(2);
		check_value("exception trap_addr", trap_addr, 32'h0000_1000);
		check_value("exception trap_is_irq", trap_is_irq, 1'b0);
		@(posedge clk);
		#10;
		except         = EXCEPT_NONE;
		trap_enter_rdy = 1'b0;
		exp_epc        = exp_epc & 32'hffff_fffe;
		read_csr(MEPC);
		check_value("mepc after exception", rd_data, exp_epc);
		read_csr(MCAUSE);
		check_value("mcause after exception", rd_data, 32'h0000_0008);
		read_csr(MSTATUS);
		check_value("mstatus after exception", rd_data, 32'h0000_1880); // mpie holds old mie
		end_test("exception entry");

		write_csr(CSR_WTYPE_W, MTVEC, 32'h0000_2001); // Vectored
		write_csr(CSR_WTYPE_W, MIE, 32'h0000_0800);   // External only
		for (int i = 0; i < 3; i++) begin
			write_csr(CSR_WTYPE_S, MSTATUS, 32'h0000_0008);
			k  = $random(seed) & 15;
			d1 = $random(seed);
			@(posedge clk);
			#10;
			irq = (d1[15:0] << k) | (16'h1 << k); // Lowest set bit is k
			wait_vld(3);
			check_value("external trap_addr", trap_addr, 32'h2000 + 4 * (16 + k));
			check_value("external trap_is_irq", trap_is_irq, 1'b1);
			read_csr(MLEI);
			check_value("mlei", rd_data, 32'(k));
			complete_handshake();
			irq = '0;
			read_csr(MCAUSE);
			check_value("mcause after external", rd_data, 32'h8000_0000 | (16 + k));
		end
		end_test("external interrupt vectoring");

		write_csr(CSR_WTYPE_W, MIE, 32'h0000_0880); // Timer and external
		write_csr(CSR_WTYPE_S, MSTATUS, 32'h0000_0008);
		@(posedge clk);
		#10;
		irq_timer = 1'b1;
		irq       = 16'h1 << ($random(seed) & 15);
		wait_vld(3);
		check_value("timer trap_addr", trap_addr, 32'h0000_201c); // Vector 7
		check_value("timer trap_is_irq", trap_is_irq, 1'b1);
		complete_handshake();
		irq_timer = 1'b0;
		irq       = '0;
		read_csr(MCAUSE);
		check_value("mcause after timer", rd_data, 32'h8000_0007);
		end_test("timer over external");

		d1 = $random(seed);
		write_csr(CSR_WTYPE_W, MSTATUS, {24'h0, d1[0], 7'h0}); // mpie random, mie=0
		@(posedge clk);
		#10;
		except = EXCEPT_MRET;
		wait_vld(2);
		check_value("mret trap_addr", trap_addr, exp_epc);
		check_value("mret trap_is_irq", trap_is_irq, 1'b0);
		repeat (2) @(posedge clk); // rdy stays low
		read_csr(MSTATUS);
		check_value("mstatus while rdy low", rd_data, 32'h1800 | (32'(d1[0]) << 7));
		complete_handshake();
		except = EXCEPT_NONE;
		read_csr(MSTATUS);
		check_value("mstatus after mret", rd_data, 32'h1880 | (32'(d1[0]) << 3));
		end_test("mret return");

		$display("Tests run %0d, failed %0d, value errors %0d, assertion failures %0d",
			tests, failed_tests, errors, u_dut.u_props.fail_cnt);
		if (failed_tests == 0 && u_dut.u_props.fail_cnt == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== test/tb_csr_properties.sv ====
`timescale 1ns/1ps

module tb_csr_properties #(
	parameter int NUM_IRQ = 16
) (
	input logic                     clk,
	input logic                     rst_n,
	input csr_pkg::csr_addr_t       addr,
	input logic                     wen,
	input logic                     ren,
	input logic                     illegal,
	input csr_pkg::except_t         except,
	input logic [NUM_IRQ-1:0]       irq,
	input logic                     irq_timer,
	input logic                     irq_software,
	input csr_pkg::trap_state_t     state,
	input logic                     trap_enter_vld,
	input logic                     trap_enter_rdy,
	input logic [csr_pkg::XLEN-1:0] trap_addr
);

	import csr_pkg::*;

	int   fail_cnt = 0; // Failed property count
	logic mapped;       // Address of a kept CSR
	logic ro_addr;      // meip0 or mlei
	logic irq_now;      // Enabled line present at the input pins

	assign mapped  = addr inside {MSTATUS, MIE, MTVEC, MSCRATCH, MEPC, MCAUSE, MIP,
		MEIE0, MEIP0, MLEI};
	assign ro_addr = addr inside {MEIP0, MLEI};
	assign irq_now = state.mstatus_mie && ((irq_timer && state.mie[7]) ||
		(irq_software && state.mie[3]) ||
		(state.mie[11] && |(irq & state.meie0[NUM_IRQ-1:0])));

	// ------------------------------------------------------------------
	// Reset and access rules
	// ------------------------------------------------------------------

	a_vld_in_reset: assert property (@(posedge clk) !rst_n |-> !trap_enter_vld)
	else begin
		fail_cnt++;
		$error("trap_enter_vld high during reset");
	end

	a_illegal: assert property (@(posedge clk)
		illegal == ((wen || ren) && !(mapped && !(wen && ro_addr))))
	else begin
		fail_cnt++;
		$error("illegal does not match the access rule");
	end

	// ------------------------------------------------------------------
	// Trap handshake timing
	// ------------------------------------------------------------------

	// Lines are sampled once, so vld comes on the next cycle
	a_irq_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		(!trap_enter_vld && irq_now && !wen) |=> trap_enter_vld)
	else begin
		fail_cnt++;
		$error("trap_enter_vld did not rise one cycle after an enabled interrupt");
	end

	a_hold_no_rdy: assert property (@(posedge clk) disable iff (!rst_n)
		(trap_enter_vld && !trap_enter_rdy && !wen && $stable(irq) &&
		$stable(irq_timer) && $stable(irq_software)) ##1 $stable(except)
		|-> $stable(trap_enter_vld) && $stable(trap_addr))
	else begin
		fail_cnt++;
		$error("trap_enter_vld or trap_addr moved while rdy was low");
	end

	a_state_no_rdy: assert property (@(posedge clk) disable iff (!rst_n)
		(!trap_enter_rdy && !wen) |=> $stable(state.mstatus_mie) &&
		$stable(state.mstatus_mpie) && $stable(state.mcause_code))
	else begin
		fail_cnt++;
		$error("trap state changed with no handshake and no write");
	end

endmodule

bind csr_top tb_csr_properties #(.NUM_IRQ(NUM_IRQ)) u_props (.*);

// ==== verilog/csr_access_decode.sv ====
`timescale 1ns/1ps

module csr_access_decode (
	input  csr_pkg::csr_addr_t       addr,
	input  logic [csr_pkg::XLEN-1:0] wdata,
	input  csr_pkg::csr_wtype_t      wtype,
	input  logic                     wen,
	input  logic                     ren,
	output csr_pkg::csr_sel_t        sel,
	output csr_pkg::csr_wr_t         wr,
	output logic                     illegal
);

	import csr_pkg::*;

	logic ro_hit;       // Address of a read-only register
	logic decode_match; // Access lands on something real

	// ------------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------------

	always_comb begin
		sel = '0;
		case (addr)
			MSTATUS:  sel.mstatus  = 1'b1;
			MIE:      sel.mie      = 1'b1;
			MTVEC:    sel.mtvec    = 1'b1;
			MSCRATCH: sel.mscratch = 1'b1;
			MEPC:     sel.mepc     = 1'b1;
			MCAUSE:   sel.mcause   = 1'b1;
			MIP:      sel.mip      = 1'b1; // Writable but writes dropped
			MEIE0:    sel.meie0    = 1'b1;
			MEIP0:    sel.meip0    = 1'b1;
			MLEI:     sel.mlei     = 1'b1;
			default:  sel          = '0;  // Unmapped
		endcase
	end

	assign ro_hit = sel.meip0 || sel.mlei;

	// Write to a read-only register counts as no match
	assign decode_match = (|sel) && !(wen && ro_hit);

	assign illegal = (wen || ren) && !decode_match;

	// Write strobe goes on only when legal
	always_comb begin
		wr.en       = wen && decode_match;
		wr.wtype    = wtype;
		wr.data.raw = wdata;
	end

endmodule

// ==== verilog/csr_pkg.sv ====
package csr_pkg;

	// ------------------------------------------------------------------
	// Widths and CSR map
	// ------------------------------------------------------------------

	localparam int XLEN = 32; // Data word width

	typedef logic [11:0] csr_addr_t;

	// Machine trap setup and handling
	localparam csr_addr_t MSTATUS  = 12'h300;
	localparam csr_addr_t MIE      = 12'h304;
	localparam csr_addr_t MTVEC    = 12'h305;
	localparam csr_addr_t MSCRATCH = 12'h340;
	localparam csr_addr_t MEPC     = 12'h341;
	localparam csr_addr_t MCAUSE   = 12'h342;
	localparam csr_addr_t MIP      = 12'h344;

	// Custom external interrupt controller
	localparam csr_addr_t MEIE0    = 12'hbe0; // Enable, one bit per line
	localparam csr_addr_t MEIP0    = 12'hfe0; // Pending, read-only
	localparam csr_addr_t MLEI     = 12'hfe4; // Lowest pending line, read-only

	typedef enum logic [1:0] {
		CSR_WTYPE_W = 2'h0, // Plain write
		CSR_WTYPE_S = 2'h1, // Set bits
		CSR_WTYPE_C = 2'h2  // Clear bits
	} csr_wtype_t;

	// Synchronous causes from the core, NONE when idle
	typedef enum logic [3:0] {
		EXCEPT_INSTR_MISALIGN = 4'h0,
		EXCEPT_INSTR_FAULT    = 4'h1,
		EXCEPT_INSTR_ILLEGAL  = 4'h2,
		EXCEPT_EBREAK         = 4'h3,
		EXCEPT_LOAD_ALIGN     = 4'h4,
		EXCEPT_LOAD_FAULT     = 4'h5,
		EXCEPT_STORE_ALIGN    = 4'h6,
		EXCEPT_STORE_FAULT    = 4'h7,
		EXCEPT_ECALL          = 4'h8,
		EXCEPT_MRET           = 4'hb, // Return, not a real exception
		EXCEPT_NONE           = 4'hf
	} except_t;

	localparam logic [XLEN-1:0] MIE_WMASK  = 32'h0000_0888; // meie, mtie, msie
	localparam logic [XLEN-1:0] MTVEC_INIT = 32'h0000_0000; // Direct mode at 0

	// ------------------------------------------------------------------
	// Structs
	// ------------------------------------------------------------------

	typedef struct packed {
		logic [23:0] rsvd_hi; // MPP sits in here, fixed on read
		logic        mpie;    // Bit 7
		logic [2:0]  rsvd_mid;
		logic        mie;     // Bit 3
		logic [2:0]  rsvd_lo;
	} mstatus_view_t;

	// Same word seen whole, or by mstatus field
	typedef union packed {
		logic [XLEN-1:0] raw;
		mstatus_view_t   mstatus;
	} csr_word_u;

	// One-hot register selects
	typedef struct packed {
		logic mstatus;
		logic mie;
		logic mtvec;
		logic mscratch;
		logic mepc;
		logic mcause;
		logic mip;
		logic meie0;
		logic meip0;
		logic mlei;
	} csr_sel_t;

	typedef struct packed {
		logic       en;    // Legal write this cycle
		csr_wtype_t wtype;
		csr_word_u  data;
	} csr_wr_t;

	typedef struct packed {
		logic            mstatus_mie;
		logic            mstatus_mpie;
		logic [XLEN-1:0] mie;
		logic [XLEN-1:0] mtvec;
		logic [XLEN-1:0] mepc;
		logic            mcause_irq;
		logic [5:0]      mcause_code;
		logic [XLEN-1:0] mscratch;
		logic [XLEN-1:0] meie0;
		logic [XLEN-1:0] meip0; // Sampled external lines, zero above NUM_IRQ
		logic            mtip;  // Sampled timer line
		logic            msip;  // Sampled software line
	} trap_state_t;

	typedef struct packed {
		logic       fire;    // vld and rdy on this edge
		logic       is_mret;
		logic       cause_irq;
		logic [5:0] cause_code;
	} trap_take_t;

	// Write, set or clear, only where wmask has a 1
	function automatic logic [XLEN-1:0] csr_update(
		input logic [XLEN-1:0] prev,
		input csr_wtype_t      wtype,
		input logic [XLEN-1:0] wdata,
		input logic [XLEN-1:0] wmask
	);
		logic [XLEN-1:0] raw;
		raw = wtype == CSR_WTYPE_C ? prev & ~wdata :
			wtype == CSR_WTYPE_S ? prev | wdata : wdata;
		return (raw & wmask) | (prev & ~wmask);
	endfunction

endpackage

// ==== verilog/csr_read_mux.sv ====
`timescale 1ns/1ps

module csr_read_mux (
	input  csr_pkg::csr_sel_t        sel,
	input  csr_pkg::trap_state_t     state,
	input  logic [4:0]               mlei,
	output logic [csr_pkg::XLEN-1:0] rdata
);

	import csr_pkg::*;

	localparam logic [XLEN-1:0] MSTATUS_RO = 32'h0000_1800; // MPP=11, always M-mode

	csr_word_u       mstatus_rd;
	logic [XLEN-1:0] mtvec_rd;
	logic [XLEN-1:0] mcause_rd;
	logic [XLEN-1:0] mip_rd;
	logic            meip;

	assign meip = |(state.meie0 & state.meip0); // Global external pending

	// Constant bits first, then the live fields on top
	always_comb begin
		mstatus_rd.raw          = MSTATUS_RO;
		mstatus_rd.mstatus.mie  = state.mstatus_mie;
		mstatus_rd.mstatus.mpie = state.mstatus_mpie;
	end

	assign mtvec_rd  = {state.mtvec[XLEN-1:2], 1'b0, state.mtvec[0]}; // Base, mode
	assign mcause_rd = {state.mcause_irq, 26'h0, state.mcause_code[4:0]};
	assign mip_rd    = {20'h0, meip, 3'h0, state.mtip, 3'h0, state.msip, 3'h0};

	// ------------------------------------------------------------------
	// AND-OR read mux over one-hot selects
	// ------------------------------------------------------------------

	always_comb begin
		rdata = '0;
		rdata |= {XLEN{sel.mstatus}}  & mstatus_rd.raw;
		rdata |= {XLEN{sel.mie}}      & state.mie;
		rdata |= {XLEN{sel.mtvec}}    & mtvec_rd;
		rdata |= {XLEN{sel.mscratch}} & state.mscratch;
		rdata |= {XLEN{sel.mepc}}     & state.mepc;
		rdata |= {XLEN{sel.mcause}}   & mcause_rd;
		rdata |= {XLEN{sel.mip}}      & mip_rd;
		rdata |= {XLEN{sel.meie0}}    & state.meie0;
		rdata |= {XLEN{sel.meip0}}    & state.meip0;
		rdata |= {XLEN{sel.mlei}}     & XLEN'(mlei);
	end

endmodule

// ==== verilog/csr_top.sv ====
`timescale 1ns/1ps

module csr_top #(
	parameter int NUM_IRQ = 16
) (
	input  logic                     clk,
	input  logic                     rst_n,
	// CSR access, single-cycle strobes
	input  csr_pkg::csr_addr_t       addr,
	input  logic [csr_pkg::XLEN-1:0] wdata,
	input  csr_pkg::csr_wtype_t      wtype,
	input  logic                     wen,
	input  logic                     ren,
	output logic [csr_pkg::XLEN-1:0] rdata,   // Same cycle
	output logic                     illegal, // Same cycle
	// Trap causes from the core
	input  csr_pkg::except_t         except,
	input  logic [csr_pkg::XLEN-1:0] mepc_in,
	// Level-sensitive interrupt lines
	input  logic [NUM_IRQ-1:0]       irq,
	input  logic                     irq_timer,
	input  logic                     irq_software,
	// Trap handshake
	output logic [csr_pkg::XLEN-1:0] trap_addr,
	output logic                     trap_is_irq,
	output logic                     trap_enter_vld,
	input  logic                     trap_enter_rdy
);

	csr_pkg::csr_sel_t    sel;
	csr_pkg::csr_wr_t     wr;
	csr_pkg::trap_state_t state;
	csr_pkg::trap_take_t  take;
	logic [4:0]           mlei;

	csr_access_decode u_decode (
		.addr    (addr),
		.wdata   (wdata),
		.wtype   (wtype),
		.wen     (wen),
		.ren     (ren),
		.sel     (sel),
		.wr      (wr),
		.illegal (illegal)
	);

	machine_trap_regs #(.NUM_IRQ(NUM_IRQ)) u_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.sel          (sel),
		.wr           (wr),
		.take         (take),
		.mepc_in      (mepc_in),
		.irq          (irq),
		.irq_timer    (irq_timer),
		.irq_software (irq_software),
		.state        (state)
	);

	trap_request #(.NUM_IRQ(NUM_IRQ)) u_req (
		.except         (except),
		.trap_enter_rdy (trap_enter_rdy),
		.state          (state),
		.trap_addr      (trap_addr),
		.trap_is_irq    (trap_is_irq),
		.trap_enter_vld (trap_enter_vld),
		.take           (take),
		.mlei           (mlei)
	);

	csr_read_mux u_rmux (
		.sel   (sel),
		.state (state),
		.mlei  (mlei),
		.rdata (rdata)
	);

endmodule

// ==== verilog/machine_trap_regs.sv ====
`timescale 1ns/1ps

module machine_trap_regs #(
	parameter int NUM_IRQ = 16
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  csr_pkg::csr_sel_t        sel,
	input  csr_pkg::csr_wr_t         wr,
	input  csr_pkg::trap_take_t      take,
	input  logic [csr_pkg::XLEN-1:0] mepc_in,
	input  logic [NUM_IRQ-1:0]       irq,
	input  logic                     irq_timer,
	input  logic                     irq_software,
	output csr_pkg::trap_state_t     state
);

	import csr_pkg::*;

	localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h0000_0088; // mpie, mie
	localparam logic [XLEN-1:0] MTVEC_WMASK   = 32'hffff_fffd; // Base and mode bit 0
	localparam logic [XLEN-1:0] MCAUSE_WMASK  = 32'h8000_003f; // Irq flag, 6-bit code
	localparam logic [XLEN-1:0] MEPC_MASK     = 32'hffff_fffe; // Bit 0 always 0
	localparam logic [XLEN-1:0] MEIE0_WMASK   = ~({XLEN{1'b1}} << NUM_IRQ);

	// Two-level enable stack
	logic mstatus_mie;
	logic mstatus_mpie;

	logic [XLEN-1:0] mie;
	logic [XLEN-1:0] mtvec;
	logic [XLEN-1:0] mepc;
	logic [XLEN-1:0] mscratch;
	logic [XLEN-1:0] meie0;
	logic            mcause_irq;
	logic [5:0]      mcause_code;

	// Interrupt lines registered once
	logic [NUM_IRQ-1:0] irq_r;
	logic               irq_timer_r;
	logic               irq_software_r;

	logic            trap_entry; // Handshake other than mret
	logic            trap_exit;  // Handshake on mret
	mstatus_view_t   ms_cur;
	csr_word_u       ms_upd;
	logic [XLEN-1:0] mcause_upd;

	assign trap_entry = take.fire && !take.is_mret;
	assign trap_exit  = take.fire && take.is_mret;

	// Next values for the registers with scattered fields
	always_comb begin
		ms_cur      = '0;
		ms_cur.mie  = mstatus_mie;
		ms_cur.mpie = mstatus_mpie;
		ms_upd.raw  = csr_update(ms_cur, wr.wtype, wr.data.raw, MSTATUS_WMASK);
		mcause_upd  = csr_update({mcause_irq, 25'h0, mcause_code}, wr.wtype,
			wr.data.raw, MCAUSE_WMASK);
	end

	// ------------------------------------------------------------------
	// Trap state with trap entry ahead of software writes
	// ------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
		end else if (trap_exit) begin
			mstatus_mie  <= mstatus_mpie; // Pop
			mstatus_mpie <= 1'b1;
		end else if (trap_entry) begin
			mstatus_mpie <= mstatus_mie;  // Push then mask
			mstatus_mie  <= 1'b0;
		end else if (wr.en && sel.mstatus) begin
			mstatus_mie  <= ms_upd.mstatus.mie;
			mstatus_mpie <= ms_upd.mstatus.mpie;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mcause_irq  <= 1'b0;
			mcause_code <= 6'h0;
		end else if (trap_entry) begin
			mcause_irq  <= take.cause_irq;
			mcause_code <= take.cause_code;
		end else if (wr.en && sel.mcause) begin
			mcause_irq  <= mcause_upd[XLEN-1];
			mcause_code <= mcause_upd[5:0];
		end
	end

	// Enables and vector base written only by software
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mie   <= '0;
			mtvec <= MTVEC_INIT;
			meie0 <= MEIE0_WMASK; // Every implemented line enabled
		end else begin
			if (wr.en && sel.mie)
				mie <= csr_update(mie, wr.wtype, wr.data.raw, MIE_WMASK);
			if (wr.en && sel.mtvec)
				mtvec <= csr_update(mtvec, wr.wtype, wr.data.raw, MTVEC_WMASK);
			if (wr.en && sel.meie0)
				meie0 <= csr_update(meie0, wr.wtype, wr.data.raw, MEIE0_WMASK);
		end
	end

	// Payload words
	always_ff @(posedge clk) begin
		if (trap_entry)
			mepc <= mepc_in & MEPC_MASK;
		else if (wr.en && sel.mepc)
			mepc <= csr_update(mepc, wr.wtype, wr.data.raw, '1) & MEPC_MASK;
		if (wr.en && sel.mscratch)
			mscratch <= csr_update(mscratch, wr.wtype, wr.data.raw, '1);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_r          <= '0;
			irq_timer_r    <= 1'b0;
			irq_software_r <= 1'b0;
		end else begin
			irq_r          <= irq;
			irq_timer_r    <= irq_timer;
			irq_software_r <= irq_software;
		end
	end

	always_comb begin
		state.mstatus_mie  = mstatus_mie;
		state.mstatus_mpie = mstatus_mpie;
		state.mie          = mie;
		state.mtvec        = mtvec;
		state.mepc         = mepc;
		state.mcause_irq   = mcause_irq;
		state.mcause_code  = mcause_code;
		state.mscratch     = mscratch;
		state.meie0        = meie0;
		state.meip0        = XLEN'(irq_r); // Zero above NUM_IRQ
		state.mtip         = irq_timer_r;
		state.msip         = irq_software_r;
	end

endmodule

// ==== verilog/priority_encoder.sv ====
`timescale 1ns/1ps

// Index of the lowest set request bit
module priority_encoder #(
	parameter int W_REQ = 16
) (
	input  logic [W_REQ-1:0]         req,
	output logic [$clog2(W_REQ)-1:0] gnt
);

	localparam int W_GNT = $clog2(W_REQ);

	always_comb begin
		gnt = '0; // Also the answer for no request
		// Scan downwards, the lowest hit writes last
		for (int i = W_REQ - 1; i >= 0; i--) begin
			if (req[i])
				gnt = W_GNT'(i);
		end
	end

endmodule

// ==== verilog/trap_request.sv ====
`timescale 1ns/1ps

module trap_request #(
	parameter int NUM_IRQ = 16
) (
	input  csr_pkg::except_t         except,
	input  logic                     trap_enter_rdy,
	input  csr_pkg::trap_state_t     state,
	output logic [csr_pkg::XLEN-1:0] trap_addr,
	output logic                     trap_is_irq,
	output logic                     trap_enter_vld,
	output csr_pkg::trap_take_t      take,
	output logic [4:0]               mlei
);

	import csr_pkg::*;

	localparam int W_EXT = $clog2(NUM_IRQ);

	logic [15:0]        std_req;    // Standard pending and enabled
	logic [NUM_IRQ-1:0] ext_req;    // External pending and enabled
	logic [3:0]         std_num;
	logic [W_EXT-1:0]   ext_num;
	logic               std_active;
	logic               ext_active;
	logic               exc_any;
	logic               is_mret;
	logic [5:0]         irq_code;   // Cause number of the winning interrupt
	logic [5:0]         vector;
	logic [XLEN-1:0]    mtvec_base;

	// meip stays out of the standard set, externals vector by line number
	assign std_req = {8'h0, state.mtip, 3'h0, state.msip, 3'h0} & state.mie[15:0];
	assign ext_req = state.meie0[NUM_IRQ-1:0] & state.meip0[NUM_IRQ-1:0];

	priority_encoder #(.W_REQ(16)) u_std_pe (
		.req (std_req),
		.gnt (std_num)
	);

	priority_encoder #(.W_REQ(NUM_IRQ)) u_ext_pe (
		.req (ext_req),
		.gnt (ext_num)
	);

	assign mlei = 5'(ext_num);

	assign std_active = (|std_req) && state.mstatus_mie;
	assign ext_active = (|ext_req) && state.mstatus_mie && state.mie[11];

	assign exc_any = except != EXCEPT_NONE; // mret counts here too
	assign is_mret = except == EXCEPT_MRET;

	// Standard over external
	assign irq_code = std_active ? 6'(std_num) : 6'd16 + 6'(ext_num);

	// Vectoring only for interrupts in mode 1
	assign vector     = (state.mtvec[0] && !exc_any) ? irq_code : 6'd0;
	assign mtvec_base = {state.mtvec[XLEN-1:2], 2'b00};

	assign trap_addr = is_mret ? state.mepc : mtvec_base + XLEN'({vector, 2'b00});

	assign trap_is_irq    = !exc_any;
	assign trap_enter_vld = exc_any || std_active || ext_active; // Drops if cause goes

	always_comb begin
		take.fire       = trap_enter_vld && trap_enter_rdy;
		take.is_mret    = is_mret;
		take.cause_irq  = !exc_any;
		take.cause_code = exc_any ? {2'b00, except} : irq_code;
	end

endmodule
